/* dcache.f */
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_way.sv
verilog/dcache_replace.sv
verilog/dcache_top.sv
tb/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -f dcache.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    exit 1
fi

/* tb/dcache_testdata.txt */
// op (0 read, 1 write, f end) | addr | wdata | wsel | hit | rdata | line reads | wb addr
// memory word at address a is a ^ 5a3c96e1 until written back, ffffffff means no write-back
0 00001044 00000000 0 0 5a3c86a5 1 ffffffff
0 0000105c 00000000 0 1 5a3c86bd 0 ffffffff
// partial write hit, bytes 0 and 2
1 00001048 11223344 5 1 00000000 0 ffffffff
0 00001048 00000000 0 1 5a228644 0 ffffffff
// lru in set 3, C evicts B
0 00002064 00000000 0 0 5a3cb685 1 ffffffff
0 00003060 00000000 0 0 5a3ca681 1 ffffffff
0 00002064 00000000 0 1 5a3cb685 0 ffffffff
0 00004068 00000000 0 0 5a3cd689 1 ffffffff
0 00003060 00000000 0 0 5a3ca681 1 ffffffff
// write miss in set 5
1 000050a4 cafef00d f 0 00000000 1 ffffffff
0 000050a4 00000000 0 1 cafef00d 0 ffffffff
// dirty line 1040 goes back before the refill
0 0000204c 00000000 0 0 5a3cb6ad 1 ffffffff
0 00003040 00000000 0 0 5a3ca6a1 1 00001040
0 00001048 00000000 0 0 5a228644 1 ffffffff
0 00001044 00000000 0 1 5a3c86a5 0 ffffffff
// write-miss line 50a0 evicted
0 000060a0 00000000 0 0 5a3cf641 1 ffffffff
0 000070a0 00000000 0 0 5a3ce641 1 000050a0
0 000050a4 00000000 0 0 cafef00d 1 ffffffff
1 000050a4 99887766 8 1 00000000 0 ffffffff
0 000050a4 00000000 0 1 99fef00d 0 ffffffff
f 00000000 00000000 0 0 00000000 0 00000000

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int    MAX_OPS     = 32;
    localparam int    TIMEOUT     = 100;
    localparam word_t PATTERN_KEY = 32'h5a3c96e1;

    logic        clk;
    logic        rst;
    logic        cpu_rreq_i;
    logic        cpu_wreq_i;
    addr_t       cpu_addr_i;
    word_t       cpu_wdata_i;
    wsel_t       cpu_wsel_i;
    logic        mem_rvalid_i;
    line_t       mem_rdata_i;
    logic        mem_bvalid_i;
    logic        hit_o;
    logic        cpu_data_valid_o;
    word_t       cpu_rdata_o;
    logic        cpu_stall_o;
    logic        mem_ren_o;
    addr_t       mem_araddr_o;
    logic        mem_wen_o;
    addr_t       mem_awaddr_o;
    line_t       mem_wdata_o;

    // eight words per operation, see the data file
    word_t       td [MAX_OPS*8];
    line_t       wb_lines [addr_t];
    int unsigned lcg_state;
    int          mem_delay;
    int          read_count;
    int          write_count;
    addr_t       last_rd_addr;
    addr_t       last_wb_addr;

    dcache_top i_dcache_top (
        .clk              (clk),
        .rst              (rst),
        .cpu_rreq_i       (cpu_rreq_i),
        .cpu_wreq_i       (cpu_wreq_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_wdata_i      (cpu_wdata_i),
        .cpu_wsel_i       (cpu_wsel_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .hit_o            (hit_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_rdata_o      (cpu_rdata_o),
        .cpu_stall_o      (cpu_stall_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o),
        .mem_wdata_o      (mem_wdata_o)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    // untouched memory holds each word's own address scrambled
    function automatic line_t pattern_line(addr_t line_addr);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i * WORD_W +: WORD_W] = (line_addr + addr_t'(i * 4)) ^ PATTERN_KEY;
        end
        return l;
    endfunction

    ////////////////////
    // memory model
    ////////////////////

    always @(negedge clk) begin
        mem_rvalid_i = 1'b0;
        mem_bvalid_i = 1'b0;
        if (!rst && (mem_ren_o || mem_wen_o)) begin
            if (mem_delay == 0) begin
                mem_delay = 1 + int'(next_rand() % 6);
            end
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                if (mem_wen_o) begin
                    assert (mem_awaddr_o[OFFSET_W-1:0] == '0) else
                        stop_with_error("write-back address is not line aligned");
                    assert (read_count == 0) else
                        stop_with_error("line write-back came after the refill");
                    wb_lines[mem_awaddr_o] = mem_wdata_o;
                    last_wb_addr = mem_awaddr_o;
                    write_count++;
                    mem_bvalid_i = 1'b1;
                end else begin
                    assert (mem_araddr_o[OFFSET_W-1:0] == '0) else
                        stop_with_error("refill address is not line aligned");
                    mem_rdata_i = wb_lines.exists(mem_araddr_o) ? wb_lines[mem_araddr_o]
                                                                : pattern_line(mem_araddr_o);
                    last_rd_addr = mem_araddr_o;
                    read_count++;
                    mem_rvalid_i = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // operations
    ////////////////////

    task automatic run_op(int n);
        word_t op;
        addr_t addr;
        word_t exp_rdata;
        word_t exp_reads;
        word_t exp_wb;
        int    wait_count;
        string tag;
        op        = td[n*8];
        addr      = td[n*8+1];
        exp_rdata = td[n*8+5];
        exp_reads = td[n*8+6];
        exp_wb    = td[n*8+7];
        tag       = $sformatf("op%0d", n);
        read_count  = 0;
        write_count = 0;
        @(negedge clk);
        cpu_rreq_i  = (op == 0);
        cpu_wreq_i  = (op == 1);
        cpu_addr_i  = addr;
        cpu_wdata_i = td[n*8+2];
        cpu_wsel_i  = td[n*8+3][3:0];
        @(negedge clk);
        cpu_rreq_i = 1'b0;
        cpu_wreq_i = 1'b0;
        // compare cycle
        #1;
        check_value({tag, "_hit"}, td[n*8+4], {31'b0, hit_o});
        if (!hit_o) begin
            check_value({tag, "_stall"}, 32'd1, {31'b0, cpu_stall_o});
            wait_count = 0;
            do begin
                @(negedge clk);
                #1;
                wait_count++;
                assert (wait_count <= TIMEOUT) else
                    stop_with_error($sformatf("%s timed out waiting for the miss to finish", tag));
            end while (cpu_stall_o);
        end
        check_value({tag, "_valid"}, (op == 0) ? 32'd1 : 32'd0, {31'b0, cpu_data_valid_o});
        if (op == 0) begin
            check_value({tag, "_rdata"}, exp_rdata, cpu_rdata_o);
        end
        check_value({tag, "_reads"}, exp_reads, word_t'(read_count));
        if (exp_reads != 0) begin
            check_value({tag, "_araddr"}, {addr[ADDR_W-1:OFFSET_W], 5'b0}, last_rd_addr);
        end
        if (exp_wb == 32'hffffffff) begin
            check_value({tag, "_writes"}, 32'd0, word_t'(write_count));
        end else begin
            check_value({tag, "_writes"}, 32'd1, word_t'(write_count));
            check_value({tag, "_awaddr"}, exp_wb, last_wb_addr);
        end
    endtask

    initial begin
        int n;
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_rreq_i   = 1'b0;
        cpu_wreq_i   = 1'b0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        cpu_wsel_i   = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_bvalid_i = 1'b0;
        lcg_state    = 65;
        mem_delay    = 0;
        read_count   = 0;
        write_count  = 0;
        last_rd_addr = '0;
        last_wb_addr = '0;
        $readmemh("tb/dcache_testdata.txt", td);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("reset_stall", 32'd0, {31'b0, cpu_stall_o});
        check_value("reset_valid", 32'd0, {31'b0, cpu_data_valid_o});
        check_value("reset_hit", 32'd0, {31'b0, hit_o});
        check_value("reset_mem_ren", 32'd0, {31'b0, mem_ren_o});
        check_value("reset_mem_wen", 32'd0, {31'b0, mem_wen_o});
        n = 0;
        while (n < MAX_OPS && td[n*8] != 32'hf) begin
            run_op(n);
            n++;
        end
        assert (n > 0) else stop_with_error("no operations were read from the data file");
        $display("all tests passed");
        $finish;
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_rreq_i,
    input  logic               cpu_wreq_i,
    input  dcache_pkg::addr_t  cpu_addr_i,
    input  dcache_pkg::word_t  cpu_wdata_i,
    input  dcache_pkg::wsel_t  cpu_wsel_i,
    input  logic               mem_rvalid_i,
    input  dcache_pkg::line_t  mem_rdata_i,
    input  logic               mem_bvalid_i,
    output logic               hit_o,
    output logic               cpu_data_valid_o,
    output dcache_pkg::word_t  cpu_rdata_o,
    output logic               cpu_stall_o,
    output logic               mem_ren_o,
    output dcache_pkg::addr_t  mem_araddr_o,
    output logic               mem_wen_o,
    output dcache_pkg::addr_t  mem_awaddr_o,
    output dcache_pkg::line_t  mem_wdata_o
);

    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

    addr_t            addr_q;
    word_t            wdata_q;
    wsel_t            wsel_q;
    cache_state_e     state;
    logic             is_write;
    logic             write_hit;
    logic             fill;
    logic             victim_way;
    logic             victim_dirty;
    logic [INDEX_W-1:0] ram_index;
    logic [INDEX_W-1:0] index_q;
    logic [TAG_W-1:0] tag_q;
    word_idx_t        word_idx;
    word_t            wmask;
    logic [1:0]       way_hit;
    line_t            way_line [2];
    logic [TAG_W-1:0] way_tag  [2];
    line_t            hit_line;
    line_t            way_wdata;

    function automatic line_t merge_word(line_t base, word_idx_t idx, word_t data, word_t mask);
        line_t merged;
        merged = base;
        merged[int'(idx) * WORD_W +: WORD_W] =
            (data & mask) | (base[int'(idx) * WORD_W +: WORD_W] & ~mask);
        return merged;
    endfunction

    ////////////////////
    // request latch
    ////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_LOOK_UP) begin
            addr_q  <= cpu_addr_i;
            wdata_q <= cpu_wdata_i;
            wsel_q  <= cpu_wsel_i;
        end
    end

    assign index_q   = addr_q[OFFSET_W +: INDEX_W];
    assign tag_q     = addr_q[ADDR_W-1 -: TAG_W];
    assign word_idx  = addr_q[OFFSET_W-1:2];
    // incoming address only while idle
    assign ram_index = (state == ST_LOOK_UP) ? cpu_addr_i[OFFSET_W +: INDEX_W] : index_q;
    assign wmask     = {{8{wsel_q[3]}}, {8{wsel_q[2]}}, {8{wsel_q[1]}}, {8{wsel_q[0]}}};

    ////////////////////
    // line data paths
    ////////////////////

    assign hit_line  = way_hit[1] ? way_line[1] : way_line[0];
    // write miss merges into the fetched line, read miss fills it as is
    assign way_wdata = fill ? (is_write ? merge_word(mem_rdata_i, word_idx, wdata_q, wmask)
                                        : mem_rdata_i)
                            : merge_word(hit_line, word_idx, wdata_q, wmask);

    assign cpu_rdata_o = (state == ST_REFILL) ? mem_rdata_i[int'(word_idx) * WORD_W +: WORD_W]
                                              : hit_line[int'(word_idx) * WORD_W +: WORD_W];

    assign mem_araddr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_awaddr_o = {way_tag[victim_way], index_q, {OFFSET_W{1'b0}}};
    assign mem_wdata_o  = way_line[victim_way];

    dcache_ctrl i_dcache_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_rreq_i       (cpu_rreq_i),
        .cpu_wreq_i       (cpu_wreq_i),
        .way_hit_i        (|way_hit),
        .victim_dirty_i   (victim_dirty),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .state_o          (state),
        .is_write_o       (is_write),
        .hit_o            (hit_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_stall_o      (cpu_stall_o),
        .mem_ren_o        (mem_ren_o),
        .mem_wen_o        (mem_wen_o),
        .write_hit_o      (write_hit),
        .fill_o           (fill)
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_way #(.INDEX_W(INDEX_W)) i_dcache_way (
            .clk         (clk),
            .rst         (rst),
            .ram_index_i (ram_index),
            .cmp_tag_i   (tag_q),
            .fill_i      (fill && (victim_way == w[0])),
            .word_we_i   ((write_hit && way_hit[w]) ? wsel_q : 4'b0000),
            .word_idx_i  (word_idx),
            .wdata_i     (way_wdata),
            .hit_o       (way_hit[w]),
            .line_o      (way_line[w]),
            .tag_o       (way_tag[w])
        );
    end

    dcache_replace #(.INDEX_W(INDEX_W)) i_dcache_replace (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index_q),
        .hit_way_i      (way_hit[1]),
        .touch_i        (hit_o),
        .write_hit_i    (write_hit),
        .fill_i         (fill),
        .fill_dirty_i   (is_write),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

endmodule

/* verilog/dcache_replace.sv */
`timescale 1ns/1ps

module dcache_replace #(
    parameter int INDEX_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               hit_way_i,
    input  logic               touch_i,
    input  logic               write_hit_i,
    input  logic               fill_i,
    input  logic               fill_dirty_i,
    output logic               victim_way_o,
    output logic               victim_dirty_o
);

    localparam int SETS = 2 ** INDEX_W;

    // lru bit names the way to evict next
    logic [SETS-1:0]      lru_q;
    logic [SETS-1:0][1:0] dirty_q;

    assign victim_way_o   = lru_q[index_i];
    assign victim_dirty_o = dirty_q[index_i][victim_way_o];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~hit_way_i;
            end else if (fill_i) begin
                lru_q[index_i] <= ~victim_way_o;
            end
            if (write_hit_i) begin
                dirty_q[index_i][hit_way_i] <= 1'b1;
            end else if (fill_i) begin
                dirty_q[index_i][victim_way_o] <= fill_dirty_i;
            end
        end
    end

    a_write_hit_touch: assert property (@(posedge clk) disable iff (rst)
        write_hit_i |-> touch_i);

endmodule

/* verilog/dcache_way.sv */
`timescale 1ns/1ps

module dcache_way #(
    parameter int   INDEX_W = 7,
    localparam int  TAG_W   = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_W-1:0]     ram_index_i,
    input  logic [TAG_W-1:0]       cmp_tag_i,
    input  logic                   fill_i,
    input  dcache_pkg::wsel_t      word_we_i,
    input  dcache_pkg::word_idx_t  word_idx_i,
    input  dcache_pkg::line_t      wdata_i,
    output logic                   hit_o,
    output dcache_pkg::line_t      line_o,
    output logic [TAG_W-1:0]       tag_o
);

    import dcache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    line_t            line_mem [SETS];
    logic [TAG_W-1:0] tag_mem  [SETS];
    logic [SETS-1:0]  valid_q;
    logic             valid_rd_q;

    // valid bit per set, read alongside the arrays
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            valid_rd_q <= valid_q[ram_index_i];
            if (fill_i) begin
                valid_q[ram_index_i] <= 1'b1;
            end
        end
    end

    ////////////////////
    // tag and data arrays
    ////////////////////

    always_ff @(posedge clk) begin
        if (fill_i) begin
            line_mem[ram_index_i] <= wdata_i;
            tag_mem[ram_index_i]  <= cmp_tag_i;
        end else begin
            // byte lanes of one word on a write hit
            for (int b = 0; b < $bits(wsel_t); b++) begin
                if (word_we_i[b]) begin
                    line_mem[ram_index_i][int'(word_idx_i) * WORD_W + b * 8 +: 8] <=
                        wdata_i[int'(word_idx_i) * WORD_W + b * 8 +: 8];
                end
            end
        end
    end

    // synchronous read, one cycle behind the index
    always_ff @(posedge clk) begin
        line_o <= line_mem[ram_index_i];
        tag_o  <= tag_mem[ram_index_i];
    end

    assign hit_o = valid_rd_q && (tag_o == cmp_tag_i);

    a_no_fill_and_word: assert property (@(posedge clk) disable iff (rst)
        !(fill_i && (word_we_i != '0)));

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_rreq_i,
    input  logic                      cpu_wreq_i,
    input  logic                      way_hit_i,
    input  logic                      victim_dirty_i,
    input  logic                      mem_rvalid_i,
    input  logic                      mem_bvalid_i,
    output dcache_pkg::cache_state_e  state_o,
    output logic                      is_write_o,
    output logic                      hit_o,
    output logic                      cpu_data_valid_o,
    output logic                      cpu_stall_o,
    output logic                      mem_ren_o,
    output logic                      mem_wen_o,
    output logic                      write_hit_o,
    output logic                      fill_o
);

    import dcache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         is_write_q;
    logic         in_compare;
    logic         refill_done;

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_LOOK_UP;
            is_write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // requests only count while idle
            if (state_q == ST_LOOK_UP && (cpu_rreq_i || cpu_wreq_i)) begin
                is_write_q <= cpu_wreq_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOK_UP: begin
                if (cpu_rreq_i || cpu_wreq_i) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (way_hit_i) begin
                    state_d = ST_LOOK_UP;
                end else if (victim_dirty_i) begin
                    state_d = ST_WRITE_BACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_WRITE_BACK: begin
                // victim line accepted, go fetch the new one
                if (mem_bvalid_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_rvalid_i) begin
                    state_d = ST_LOOK_UP;
                end
            end
            default: state_d = ST_LOOK_UP;
        endcase
    end

    ////////////////////
    // strobes
    ////////////////////

    assign in_compare  = (state_q == ST_COMPARE);
    assign refill_done = (state_q == ST_REFILL) && mem_rvalid_i;

    assign state_o    = state_q;
    assign is_write_o = is_write_q;

    assign hit_o       = in_compare && way_hit_i;
    assign write_hit_o = hit_o && is_write_q;
    assign fill_o      = refill_done;

    // reads complete on a hit or on the refill beat
    assign cpu_data_valid_o = (hit_o || refill_done) && !is_write_q;

    assign cpu_stall_o = (in_compare && !way_hit_i)
                       || (state_q == ST_WRITE_BACK)
                       || ((state_q == ST_REFILL) && !mem_rvalid_i);

    assign mem_wen_o = (state_q == ST_WRITE_BACK);
    assign mem_ren_o = (state_q == ST_REFILL);

    // memory answers only a request that is being held
    a_mem_resp: assert property (@(posedge clk) disable iff (rst)
        (!mem_rvalid_i || mem_ren_o) && (!mem_bvalid_i || mem_wen_o));

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    ////////////////////
    // geometry
    ////////////////////

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 5;
    localparam int LINE_W     = LINE_WORDS * WORD_W;

    ////////////////////
    // vector types
    ////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    // one enable per byte lane
    typedef logic [3:0]        wsel_t;
    typedef logic [2:0]        word_idx_t;

    // controller states
    typedef enum logic [1:0] {
        ST_LOOK_UP    = 2'd0,
        ST_COMPARE    = 2'd1,
        ST_WRITE_BACK = 2'd2,
        ST_REFILL     = 2'd3
    } cache_state_e;

endpackage
